// File: common/rvv_alu_pkg.sv
package rvv_alu_pkg;

  localparam int XLEN  = 32;
  localparam int ROB_W = 4;

  // register map in word addresses
  localparam logic [7:0] ADR_CTRL   = 8'h00;
  localparam logic [7:0] ADR_RS1    = 8'h01;
  localparam logic [7:0] ADR_STATUS = 8'h02;
  localparam logic [7:0] ADR_GO     = 8'h03;

  // operand and result pages where the low nibble picks the word
  localparam logic [3:0] PG_VS1   = 4'h1;
  localparam logic [3:0] PG_VS2   = 4'h2;
  localparam logic [3:0] PG_VD    = 4'h3;
  localparam logic [3:0] PG_WDATA = 4'h4;

  typedef enum logic [2:0] {
    OPIVV = 3'd0,
    OPMVV = 3'd2,
    OPIVI = 3'd3,
    OPIVX = 3'd4
  } funct3_e;

  typedef enum logic [5:0] {
    VAND = 6'd9,
    VOR  = 6'd10,
    VXOR = 6'd11
  } funct6_ari_e;

  typedef enum logic [5:0] {
    VMANDN = 6'd24,
    VMAND  = 6'd25,
    VMOR   = 6'd26,
    VMXOR  = 6'd27,
    VMORN  = 6'd28,
    VMNAND = 6'd29,
    VMNOR  = 6'd30,
    VMXNOR = 6'd31
  } funct6_mask_e;

  // funct3 decides which view applies
  typedef union packed {
    funct6_ari_e  ari;
    funct6_mask_e mask;
  } funct6_u;

  typedef enum logic [1:0] {
    EEW8  = 2'd0,
    EEW16 = 2'd1,
    EEW32 = 2'd2
  } eew_e;

  // first field is the MSB so funct6 lands at bit 0
  typedef struct packed {
    logic [ROB_W-1:0] rob_entry;
    logic [7:0]       vstart;
    eew_e             eew;
    logic             vm;
    funct3_e          funct3;
    funct6_u          funct6;
  } alu_ctrl_t;

  typedef struct packed {
    logic [ROB_W-1:0] rob_entry;
    logic             w_valid;
    logic             vxsat;
    logic             ignore_vta;
    logic             ignore_vma;
  } result_meta_t;

endpackage

// File: alu_mask/alu_operand_prep.sv
`timescale 1ns/1ps

module alu_operand_prep import rvv_alu_pkg::*; #(
  parameter int VLEN = 64
) (
  input  logic            uop_valid,
  input  alu_ctrl_t       uop_ctrl,
  input  logic [XLEN-1:0] rs1_data,
  input  logic [VLEN-1:0] vs1_data,
  input  logic [VLEN-1:0] vs2_data,
  input  logic            rs1_valid,
  input  logic            vs1_valid,
  input  logic            vs2_valid,
  input  logic            vd_valid,
  output logic            operands_ok,
  output logic [VLEN-1:0] src1,
  output logic [VLEN-1:0] src2
);

  localparam int NWORDS = VLEN / XLEN;

  logic            ari_op;
  logic            mask_op;
  logic [XLEN-1:0] rs1_splat;

  assign ari_op  = uop_ctrl.funct6.ari inside {VAND, VOR, VXOR};
  assign mask_op = uop_ctrl.funct6.mask inside {VMANDN, VMAND, VMOR, VMXOR,
                                                VMORN, VMNAND, VMNOR, VMXNOR};

  // scalar replicated per element and zero for eew 3
  always_comb begin
    case (uop_ctrl.eew)
      EEW8:    rs1_splat = {(XLEN/8){rs1_data[7:0]}};
      EEW16:   rs1_splat = {(XLEN/16){rs1_data[15:0]}};
      EEW32:   rs1_splat = rs1_data;
      default: rs1_splat = '0;
    endcase
  end

  always_comb begin
    operands_ok = 1'b0;
    src1        = '0;
    src2        = '0;
    if (uop_valid) begin
      case (uop_ctrl.funct3)
        OPIVV: begin
          if (ari_op && vs1_valid && vs2_valid) begin
            operands_ok = 1'b1;
            src1        = vs1_data;
            src2        = vs2_data;
          end
        end
        OPIVX, OPIVI: begin
          if (ari_op && rs1_valid && vs2_valid) begin
            operands_ok = 1'b1;
            src1        = {NWORDS{rs1_splat}};
            src2        = vs2_data;
          end
        end
        OPMVV: begin
          // mask logicals are unmasked only and vd supplies the prestart bits
          if (mask_op && uop_ctrl.vm && vs1_valid && vs2_valid && vd_valid) begin
            operands_ok = 1'b1;
            src1        = vs1_data;
            src2        = vs2_data;
          end
        end
        default: operands_ok = 1'b0;
      endcase
    end
  end

endmodule

// File: alu_mask/alu_mask_logic.sv
`timescale 1ns/1ps

module alu_mask_logic import rvv_alu_pkg::*; #(
  parameter int VLEN = 64
) (
  input  logic            operands_ok,
  input  alu_ctrl_t       uop_ctrl,
  input  logic [VLEN-1:0] src1,
  input  logic [VLEN-1:0] src2,
  input  logic [VLEN-1:0] vd_data,
  output result_meta_t    meta,
  output logic [VLEN-1:0] w_data
);

  logic            mask_form;
  logic [VLEN-1:0] op_res;
  logic [VLEN-1:0] prestart;

  assign mask_form = uop_ctrl.funct3 == OPMVV;

  always_comb begin
    op_res = '0;
    if (mask_form) begin
      // operand order is vs2 op vs1
      case (uop_ctrl.funct6.mask)
        VMANDN:  op_res = src2 & ~src1;
        VMAND:   op_res = src2 & src1;
        VMOR:    op_res = src2 | src1;
        VMXOR:   op_res = src2 ^ src1;
        VMORN:   op_res = src2 | ~src1;
        VMNAND:  op_res = ~(src2 & src1);
        VMNOR:   op_res = ~(src2 | src1);
        VMXNOR:  op_res = ~(src2 ^ src1);
        default: op_res = '0;
      endcase
    end else begin
      case (uop_ctrl.funct6.ari)
        VAND:    op_res = src2 & src1;
        VOR:     op_res = src2 | src1;
        VXOR:    op_res = src2 ^ src1;
        default: op_res = '0;
      endcase
    end
  end

  // bits below vstart in the mask form only
  always_comb begin
    for (int i = 0; i < VLEN; i++) begin
      prestart[i] = mask_form && (i < int'(uop_ctrl.vstart));
    end
  end

  assign w_data = operands_ok ? ((vd_data & prestart) | (op_res & ~prestart)) : '0;

  always_comb begin
    meta.rob_entry  = uop_ctrl.rob_entry;
    meta.w_valid    = operands_ok;
    meta.vxsat      = 1'b0;
    // mask results are always tail agnostic
    meta.ignore_vta = operands_ok & mask_form;
    meta.ignore_vma = 1'b0;
  end

endmodule

// File: rtl/alu_wb_ctrl.sv
`timescale 1ns/1ps

module alu_wb_ctrl import rvv_alu_pkg::*; #(
  parameter int VLEN = 64
) (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            wb_cyc,
  input  logic            wb_stb,
  input  logic            wb_we,
  input  logic [7:0]      wb_adr,
  input  logic [XLEN-1:0] wb_dat_w,
  output logic [XLEN-1:0] wb_dat_r,
  output logic            wb_ack,
  input  logic            done,
  input  result_meta_t    res_meta,
  input  logic [VLEN-1:0] res_data,
  output logic            uop_valid,
  output alu_ctrl_t       uop_ctrl,
  output logic [XLEN-1:0] rs1_data,
  output logic [VLEN-1:0] vs1_data,
  output logic [VLEN-1:0] vs2_data,
  output logic [VLEN-1:0] vd_data,
  output logic            rs1_valid,
  output logic            vs1_valid,
  output logic            vs2_valid,
  output logic            vd_valid
);

  localparam int NWORDS = VLEN / XLEN;

  logic            wb_req;
  logic            wr_req;
  logic [3:0]      adr_page;
  logic [3:0]      adr_word;
  logic            word_ok;
  logic            wr_ctrl;
  logic            wr_rs1;
  logic            wr_vs1;
  logic            wr_vs2;
  logic            wr_vd;
  logic            wr_go;
  logic [XLEN-1:0] status_word;
  logic [XLEN-1:0] rd_data;

  assign wb_req   = wb_cyc & wb_stb & ~wb_ack;
  assign wr_req   = wb_req & wb_we;
  assign adr_page = wb_adr[7:4];
  assign adr_word = wb_adr[3:0];
  assign word_ok  = int'(adr_word) < NWORDS;

  assign wr_ctrl = wr_req && (wb_adr == ADR_CTRL);
  assign wr_rs1  = wr_req && (wb_adr == ADR_RS1);
  assign wr_go   = wr_req && (wb_adr == ADR_GO);
  assign wr_vs1  = wr_req && word_ok && (adr_page == PG_VS1);
  assign wr_vs2  = wr_req && word_ok && (adr_page == PG_VS2);
  assign wr_vd   = wr_req && word_ok && (adr_page == PG_VD);

  // flags in the low byte and rob_entry at bits 8..11
  assign status_word = {{(XLEN-8-ROB_W){1'b0}}, res_meta.rob_entry, 3'b000,
                        res_meta.ignore_vma, res_meta.ignore_vta, res_meta.vxsat,
                        res_meta.w_valid, done};

  always_comb begin
    rd_data = '0;
    if (adr_page == 4'h0) begin
      case (wb_adr)
        ADR_CTRL:   rd_data = {{(XLEN-$bits(alu_ctrl_t)){1'b0}}, uop_ctrl};
        ADR_RS1:    rd_data = rs1_data;
        ADR_STATUS: rd_data = status_word;
        default:    rd_data = '0;
      endcase
    end else if (word_ok) begin
      case (adr_page)
        PG_VS1:   rd_data = vs1_data[int'(adr_word)*XLEN +: XLEN];
        PG_VS2:   rd_data = vs2_data[int'(adr_word)*XLEN +: XLEN];
        PG_VD:    rd_data = vd_data[int'(adr_word)*XLEN +: XLEN];
        PG_WDATA: rd_data = res_data[int'(adr_word)*XLEN +: XLEN];
        default:  rd_data = '0;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wb_ack    <= 1'b0;
      uop_valid <= 1'b0;
      rs1_valid <= 1'b0;
      vs1_valid <= 1'b0;
      vs2_valid <= 1'b0;
      vd_valid  <= 1'b0;
    end else begin
      wb_ack    <= wb_req;
      uop_valid <= wr_go;
      // operands are consumed by the issue
      if (uop_valid) begin
        rs1_valid <= 1'b0;
        vs1_valid <= 1'b0;
        vs2_valid <= 1'b0;
        vd_valid  <= 1'b0;
      end
      if (wr_rs1) rs1_valid <= 1'b1;
      if (wr_vs1) vs1_valid <= 1'b1;
      if (wr_vs2) vs2_valid <= 1'b1;
      if (wr_vd) vd_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wb_req && !wb_we) wb_dat_r <= rd_data;
    if (wr_ctrl) uop_ctrl <= alu_ctrl_t'(wb_dat_w[$bits(alu_ctrl_t)-1:0]);
    if (wr_rs1) rs1_data <= wb_dat_w;
    if (wr_vs1) vs1_data[int'(adr_word)*XLEN +: XLEN] <= wb_dat_w;
    if (wr_vs2) vs2_data[int'(adr_word)*XLEN +: XLEN] <= wb_dat_w;
    if (wr_vd) vd_data[int'(adr_word)*XLEN +: XLEN] <= wb_dat_w;
  end

  // the issue cycle carries the ack so no operand write can refill a valid bit
  a_issue_clears_valid: assert property (@(posedge clk) disable iff (!rst_n)
    uop_valid |=> !(rs1_valid || vs1_valid || vs2_valid || vd_valid));

endmodule

// File: rtl/alu_result_reg.sv
`timescale 1ns/1ps

module alu_result_reg import rvv_alu_pkg::*; #(
  parameter int VLEN = 64
) (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            uop_valid,
  input  result_meta_t    meta,
  input  logic [VLEN-1:0] w_data,
  output logic            done,
  output result_meta_t    res_meta,
  output logic [VLEN-1:0] res_data
);

  logic done_pend;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      done      <= 1'b0;
      done_pend <= 1'b0;
      res_meta  <= '0;
      res_data  <= '0;
    end else begin
      done_pend <= uop_valid;
      // new issue drops done and raises it again once the record is held
      if (uop_valid) begin
        done     <= 1'b0;
        res_meta <= meta;
        res_data <= w_data;
      end else if (done_pend) begin
        done <= 1'b1;
      end
    end
  end

  // datapath only flags a result while the uop is issued
  a_wvalid_issued: assert property (@(posedge clk) disable iff (!rst_n)
    meta.w_valid |-> uop_valid);

  a_done_after_issue: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(done) |-> $past(uop_valid, 2));

endmodule

// File: rtl/rvv_alu_top.sv
`timescale 1ns/1ps

module rvv_alu_top import rvv_alu_pkg::*; #(
  parameter int VLEN = 64
) (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            wb_cyc,
  input  logic            wb_stb,
  input  logic            wb_we,
  input  logic [7:0]      wb_adr,
  input  logic [XLEN-1:0] wb_dat_w,
  output logic [XLEN-1:0] wb_dat_r,
  output logic            wb_ack
);

  logic            uop_valid;
  alu_ctrl_t       uop_ctrl;
  logic [XLEN-1:0] rs1_data;
  logic [VLEN-1:0] vs1_data;
  logic [VLEN-1:0] vs2_data;
  logic [VLEN-1:0] vd_data;
  logic            rs1_valid;
  logic            vs1_valid;
  logic            vs2_valid;
  logic            vd_valid;
  logic            operands_ok;
  logic [VLEN-1:0] src1;
  logic [VLEN-1:0] src2;
  result_meta_t    meta;
  logic [VLEN-1:0] w_data;
  logic            done;
  result_meta_t    res_meta;
  logic [VLEN-1:0] res_data;

  alu_wb_ctrl #(.VLEN(VLEN)) u_ctrl (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .done     (done),
    .res_meta (res_meta),
    .res_data (res_data),
    .uop_valid(uop_valid),
    .uop_ctrl (uop_ctrl),
    .rs1_data (rs1_data),
    .vs1_data (vs1_data),
    .vs2_data (vs2_data),
    .vd_data  (vd_data),
    .rs1_valid(rs1_valid),
    .vs1_valid(vs1_valid),
    .vs2_valid(vs2_valid),
    .vd_valid (vd_valid)
  );

  alu_operand_prep #(.VLEN(VLEN)) u_prep (
    .uop_valid  (uop_valid),
    .uop_ctrl   (uop_ctrl),
    .rs1_data   (rs1_data),
    .vs1_data   (vs1_data),
    .vs2_data   (vs2_data),
    .rs1_valid  (rs1_valid),
    .vs1_valid  (vs1_valid),
    .vs2_valid  (vs2_valid),
    .vd_valid   (vd_valid),
    .operands_ok(operands_ok),
    .src1       (src1),
    .src2       (src2)
  );

  alu_mask_logic #(.VLEN(VLEN)) u_logic (
    .operands_ok(operands_ok),
    .uop_ctrl   (uop_ctrl),
    .src1       (src1),
    .src2       (src2),
    .vd_data    (vd_data),
    .meta       (meta),
    .w_data     (w_data)
  );

  alu_result_reg #(.VLEN(VLEN)) u_result (
    .clk      (clk),
    .rst_n    (rst_n),
    .uop_valid(uop_valid),
    .meta     (meta),
    .w_data   (w_data),
    .done     (done),
    .res_meta (res_meta),
    .res_data (res_data)
  );

endmodule

// File: verification/tb_alu_model.svh
`ifndef TB_ALU_MODEL_SVH
`define TB_ALU_MODEL_SVH

// maximal 32-bit Galois polynomial
localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
localparam int WB_TIMEOUT = 16;

function automatic logic [63:0] next_random(input int nbits);
  logic [63:0] r;
  r = '0;
  for (int i = 0; i < nbits; i++) begin
    lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
    r = {r[62:0], lfsr[0]};
  end
  return r;
endfunction

// bit k of sent marks rs1, vs1, vs2 and vd in turn
task automatic model_result(input logic [5:0] f6, input logic [2:0] f3, input logic vm,
                            input logic [1:0] eew, input logic [7:0] vstart,
                            input logic [31:0] rs1, input logic [VLEN-1:0] vs1,
                            input logic [VLEN-1:0] vs2, input logic [VLEN-1:0] vd,
                            input logic [3:0] sent, output logic ok, output logic vta,
                            output logic [VLEN-1:0] data);
  logic [VLEN-1:0] s1;
  logic            a;
  logic            b;
  logic            r;
  logic            is_ari;
  int              ew;
  ew = (eew == 2'd0) ? 8 : ((eew == 2'd1) ? 16 : 32);
  is_ari = (f6 == 6'd9) || (f6 == 6'd10) || (f6 == 6'd11);
  s1 = vs1;
  case (f3)
    3'd0: ok = is_ari && sent[1] && sent[2];
    3'd3, 3'd4: begin
      ok = is_ari && sent[0] && sent[2];
      // every element of src1 carries the low bits of the scalar
      for (int i = 0; i < VLEN; i++) s1[i] = rs1[i % ew];
    end
    3'd2: ok = (f6 >= 6'd24) && (f6 <= 6'd31) && vm && sent[1] && sent[2] && sent[3];
    default: ok = 1'b0;
  endcase
  for (int i = 0; i < VLEN; i++) begin
    a = vs2[i];
    b = s1[i];
    case (f6)
      6'd9, 6'd25:  r = a & b;
      6'd10, 6'd26: r = a | b;
      6'd11, 6'd27: r = a ^ b;
      6'd24: r = a & ~b;
      6'd28: r = a | ~b;
      6'd29: r = ~(a & b);
      6'd30: r = ~(a | b);
      6'd31: r = ~(a ^ b);
      default: r = 1'b0;
    endcase
    if (f3 == 3'd2 && i < int'(vstart)) r = vd[i];
    data[i] = ok & r;
  end
  vta = ok && (f3 == 3'd2);
endtask

task automatic bus_write(input logic [7:0] adr, input logic [31:0] data);
  int n;
  n = 0;
  wb_cyc   = 1'b1;
  wb_stb   = 1'b1;
  wb_we    = 1'b1;
  wb_adr   = adr;
  wb_dat_w = data;
  while (n == 0 || (!wb_ack && n < WB_TIMEOUT)) begin
    @(posedge clk);
    #2;
    n++;
  end
  if (!wb_ack) begin
    $display("no ack for write to address %h", adr);
    test_errors++;
  end
  wb_cyc = 1'b0;
  wb_stb = 1'b0;
  wb_we  = 1'b0;
  @(posedge clk);
  #2;
endtask

task automatic bus_read(input logic [7:0] adr, output logic [31:0] data);
  int n;
  n = 0;
  data   = '0;
  wb_cyc = 1'b1;
  wb_stb = 1'b1;
  wb_we  = 1'b0;
  wb_adr = adr;
  while (n == 0 || (!wb_ack && n < WB_TIMEOUT)) begin
    @(posedge clk);
    #2;
    n++;
  end
  if (wb_ack) data = wb_dat_r;
  else begin
    $display("no ack for read from address %h", adr);
    test_errors++;
  end
  wb_cyc = 1'b0;
  wb_stb = 1'b0;
  @(posedge clk);
  #2;
endtask

`endif

// File: verification/tb_rvv_alu.sv
`timescale 1ns/1ps

module tb_rvv_alu;

  localparam int VLEN = 64;
  localparam int NW = VLEN / 32;
  localparam int POLL_LIMIT = 20;

  logic        clk;
  logic        rst_n;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [7:0]  wb_adr;
  logic [31:0] wb_dat_w;
  logic [31:0] wb_dat_r;
  logic        wb_ack;
  logic [31:0] lfsr;
  int          test_errors;
  int          test_count;
  int          fail_count;

  `include "tb_alu_model.svh"

  rvv_alu_top #(.VLEN(VLEN)) uut (
    .clk     (clk),
    .rst_n   (rst_n),
    .wb_cyc  (wb_cyc),
    .wb_stb  (wb_stb),
    .wb_we   (wb_we),
    .wb_adr  (wb_adr),
    .wb_dat_w(wb_dat_w),
    .wb_dat_r(wb_dat_r),
    .wb_ack  (wb_ack)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic check_value(input string what, input logic [63:0] exp, input logic [63:0] got);
    assert (got === exp) else begin
      $display("CHECK FAILED %s: expected %h, actual %h", what, exp, got);
      test_errors++;
    end
  endtask

  task automatic finish_test(input string name);
    test_count++;
    if (test_errors == 0) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: failed", name);
      fail_count++;
    end
    test_errors = 0;
  endtask

  // bit k of sent marks rs1, vs1, vs2 and vd in turn
  task automatic run_op(input string name, input logic [5:0] f6, input logic [2:0] f3,
                        input logic vm, input logic [1:0] eew, input logic [7:0] vstart,
                        input logic [3:0] sent);
    logic [31:0]     rs1;
    logic [VLEN-1:0] vs1;
    logic [VLEN-1:0] vs2;
    logic [VLEN-1:0] vd;
    logic [VLEN-1:0] got;
    logic [VLEN-1:0] exp_data;
    logic [31:0]     status;
    logic [31:0]     word;
    logic [3:0]      rob;
    logic            exp_ok;
    logic            exp_vta;
    int              polls;
    rs1 = 32'(next_random(32));
    vs1 = next_random(VLEN);
    vs2 = next_random(VLEN);
    vd  = next_random(VLEN);
    rob = 4'(next_random(4));
    bus_write(8'h00, {8'h00, rob, vstart, eew, vm, f3, f6});
    if (sent[0]) bus_write(8'h01, rs1);
    for (int k = 0; k < NW; k++) begin
      if (sent[1]) bus_write(8'h10 + 8'(k), vs1[k*32 +: 32]);
      if (sent[2]) bus_write(8'h20 + 8'(k), vs2[k*32 +: 32]);
      if (sent[3]) bus_write(8'h30 + 8'(k), vd[k*32 +: 32]);
    end
    bus_write(8'h03, 32'h1);
    polls  = 0;
    status = '0;
    while (!status[0] && polls < POLL_LIMIT) begin
      bus_read(8'h02, status);
      polls++;
    end
    if (!status[0]) begin
      $display("test %s: done never set", name);
      test_errors++;
    end
    for (int k = 0; k < NW; k++) begin
      bus_read(8'h40 + 8'(k), word);
      got[k*32 +: 32] = word;
    end
    model_result(f6, f3, vm, eew, vstart, rs1, vs1, vs2, vd, sent, exp_ok, exp_vta, exp_data);
    check_value({name, " w_data"}, exp_data, got);
    // done set while vxsat and ignore_vma stay zero
    check_value({name, " status"},
                64'({20'h0, rob, 3'b000, 1'b0, exp_vta, 1'b0, exp_ok, 1'b1}), 64'(status));
    finish_test(name);
  endtask

  initial begin
    logic [31:0] word;
    logic [5:0]  f6;
    rst_n       = 1'b0;
    wb_cyc      = 1'b0;
    wb_stb      = 1'b0;
    wb_we       = 1'b0;
    wb_adr      = '0;
    wb_dat_w    = '0;
    lfsr        = 32'd61;
    test_errors = 0;
    test_count  = 0;
    fail_count  = 0;
    repeat (4) @(posedge clk);
    #2;
    rst_n = 1'b1;

    bus_read(8'h02, word);
    check_value("reset status", 64'h0, 64'(word));
    for (int k = 0; k < NW; k++) begin
      bus_read(8'h40 + 8'(k), word);
      check_value("reset w_data", 64'h0, 64'(word));
    end
    finish_test("reset_state");

    for (int i = 9; i <= 11; i++) begin
      run_op($sformatf("opivv_f6_%0d", i), 6'(i), 3'd0, 1'b1, 2'd0, 8'd0, 4'b0110);
    end
    for (int e = 0; e < 3; e++) begin
      f6 = 6'd9 + 6'(next_random(2) % 3);
      run_op($sformatf("opivx_eew%0d", e), f6, 3'd4, 1'b1, 2'(e), 8'd0, 4'b0101);
      f6 = 6'd9 + 6'(next_random(2) % 3);
      run_op($sformatf("opivi_eew%0d", e), f6, 3'd3, 1'b1, 2'(e), 8'd0, 4'b0101);
    end
    for (int i = 24; i <= 31; i++) begin
      run_op($sformatf("opmvv_f6_%0d", i), 6'(i), 3'd2, 1'b1, 2'd0,
             8'(next_random(5)), 4'b1110);
    end

    run_op("missing_vs1", 6'd9, 3'd0, 1'b1, 2'd0, 8'd0, 4'b0100);
    run_op("missing_rs1", 6'd10, 3'd4, 1'b1, 2'd1, 8'd0, 4'b0100);
    run_op("missing_vd", 6'd25, 3'd2, 1'b1, 2'd0, 8'd5, 4'b0110);
    run_op("opmvv_vm_clear", 6'd26, 3'd2, 1'b0, 2'd0, 8'd3, 4'b1110);
    run_op("bad_funct6", 6'd5, 3'd0, 1'b1, 2'd0, 8'd0, 4'b0110);
    run_op("bad_funct3", 6'd9, 3'd1, 1'b1, 2'd0, 8'd0, 4'b0110);
    run_op("mask_f6_on_opivv", 6'd25, 3'd0, 1'b1, 2'd0, 8'd0, 4'b0110);
    run_op("after_illegal", 6'd11, 3'd0, 1'b1, 2'd0, 8'd0, 4'b0110);

    $display("tests %0d, passed %0d, failed %0d", test_count, test_count - fail_count,
             fail_count);
    if (fail_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: sources.f
+incdir+verification
common/rvv_alu_pkg.sv
alu_mask/alu_operand_prep.sv
alu_mask/alu_mask_logic.sv
rtl/alu_wb_ctrl.sv
rtl/alu_result_reg.sv
rtl/rvv_alu_top.sv
verification/tb_rvv_alu.sv

// File: Makefile
# Verilator flow for the vector mask ALU

VERILATOR   ?= verilator
FILELIST    ?= sources.f
RTL_TOP     ?= rvv_alu_top
TB_TOP      ?= tb_rvv_alu
BUILD_DIR   ?= obj_dir
JOBS        ?= 0
EXTRA_FLAGS ?=

SIM_BIN = $(BUILD_DIR)/sim_$(TB_TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert $(EXTRA_FLAGS) \
		-f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary -j $(JOBS) --timing --assert $(EXTRA_FLAGS) \
		-f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR) -o sim_$(TB_TOP)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '>>> PASS'

clean:
	rm -rf $(BUILD_DIR)
